//--- logic/cam_consts.svh
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// ------------------------------------------------------------
// Frame geometry, scaled down for simulation
// ------------------------------------------------------------
`define CAM_H_ACT   16          // Pixels per line
`define CAM_V_ACT   8           // Lines per frame

// Raster size including blanking
`define VID_H_TOTAL 24
`define VID_V_TOTAL 12
`define VID_HS_LEN  2           // Hsync width in cycles
`define VID_VS_LEN  1           // Vsync width in lines

// SCCB bus
`define SCCB_DIV    4           // sys_clk cycles per SCL half period
`define SCCB_ID     8'h42       // Sensor write address

`define CFG_NUM     6           // Register table entries

`endif

//--- logic/cam_pkg.sv
package cam_pkg;

    // One RGB565 pixel
    typedef logic [15:0] pixel_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        SHIFT,
        STOP,
        ACK
    } sccb_state_e;

    typedef enum logic [1:0] {
        REQ,
        WAIT_ACK,
        WAIT_DROP,
        DONE
    } init_state_e;

    typedef enum logic [1:0] {
        WAIT_CFG,
        WAIT_VS,
        ACTIVE
    } cap_state_e;

endpackage

//--- logic/sccb_writer.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

module sccb_writer (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       cfg_req,
    input  logic [7:0] cfg_addr,
    input  logic [7:0] cfg_data,
    output logic       cfg_ack,
    output logic       cam_scl,
    output logic       cam_sda
);
    import cam_pkg::*;

    localparam int            DW       = $clog2(`SCCB_DIV);
    localparam logic [DW-1:0] DIV_LAST = DW'(`SCCB_DIV - 1);
    localparam logic [DW-1:0] DIV_MID  = DW'(`SCCB_DIV / 2 - 1);  // SDA update point
    localparam logic [4:0]    BIT_LAST = 5'd26;                    // Three 9-bit phases

    sccb_state_e   state;
    logic [DW-1:0] div_cnt;
    logic          tick;        // Last cycle of a half period
    logic          half;        // 0 while SCL low, 1 while SCL high
    logic [4:0]    bit_cnt;
    logic [26:0]   shreg;       // ID, address, data, each with a trailing don't-care

    assign tick = (div_cnt == DIV_LAST);

    // Half period divider, parked outside a transfer
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (state == IDLE || state == ACK || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == IDLE && cfg_req) begin
            shreg <= {`SCCB_ID, 1'b1, cfg_addr, 1'b1, cfg_data, 1'b1};
        end else if (state == SHIFT && half && tick) begin
            shreg <= {shreg[25:0], 1'b0};   // Next bit after SCL high half
        end
    end

    // ------------------------------------------------------------
    // Bus sequencing
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            half    <= 1'b0;
            bit_cnt <= '0;
            cfg_ack <= 1'b0;
            cam_scl <= 1'b1;    // Bus idles high
            cam_sda <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (cfg_req) begin
                        cam_sda <= 1'b0;    // Start, SDA falls with SCL high
                        state   <= START;
                    end
                end
                START: begin
                    if (tick) begin
                        cam_scl <= 1'b0;
                        half    <= 1'b0;
                        bit_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (!half && div_cnt == DIV_MID) begin
                        cam_sda <= shreg[26];   // MSB first, mid low half
                    end
                    if (tick) begin
                        cam_scl <= ~half;
                        half    <= ~half;
                        if (half) begin
                            if (bit_cnt == BIT_LAST) begin
                                state <= STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                STOP: begin
                    if (!half && div_cnt == DIV_MID) begin
                        cam_sda <= 1'b0;        // Prepare the rising stop edge
                    end
                    if (tick) begin
                        if (half) begin
                            cam_sda <= 1'b1;    // Stop, SDA rises with SCL high
                            cfg_ack <= 1'b1;
                            state   <= ACK;
                        end else begin
                            cam_scl <= 1'b1;
                            half    <= 1'b1;
                        end
                    end
                end
                ACK: begin
                    if (!cfg_req) begin         // Hold until request drops
                        cfg_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- logic/cam_init_seq.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

module cam_init_seq (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       cfg_ack,
    output logic       cfg_req,
    output logic [7:0] cfg_addr,
    output logic [7:0] cfg_data,
    output logic       cfg_done
);
    import cam_pkg::*;

    localparam int            IW       = $clog2(`CFG_NUM);
    localparam logic [IW-1:0] IDX_LAST = IW'(`CFG_NUM - 1);

    // Register address in the high byte, value in the low byte
    localparam logic [15:0] CFG_TABLE [`CFG_NUM] = '{
        16'h1246,   // COM7, QVGA RGB output
        16'h0c10,   // COM3
        16'h1722,   // HSTART
        16'h18a4,   // HSIZE
        16'h1907,   // VSTRT
        16'h1af0    // VSIZE
    };

    init_state_e   state;
    logic [IW-1:0] idx;     // Current table entry

    // Stable while the request is up, idx only moves after ack drops
    assign cfg_addr = CFG_TABLE[idx][15:8];
    assign cfg_data = CFG_TABLE[idx][7:0];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state    <= REQ;
            idx      <= '0;
            cfg_req  <= 1'b0;
            cfg_done <= 1'b0;
        end else begin
            case (state)
                REQ: begin
                    cfg_req <= 1'b1;
                    state   <= WAIT_ACK;
                end
                WAIT_ACK: begin
                    if (cfg_ack) begin
                        cfg_req <= 1'b0;
                        state   <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    if (!cfg_ack) begin             // Handshake closed
                        if (idx == IDX_LAST) begin
                            cfg_done <= 1'b1;
                            state    <= DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= REQ;
                        end
                    end
                end
                DONE:    cfg_done <= 1'b1;          // Rest here
                default: state <= REQ;
            endcase
        end
    end

endmodule

//--- logic/cam_capture.sv
`timescale 1ns/1ps

module cam_capture (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  logic            cfg_done,
    input  logic            cam_vsync,
    input  logic            cam_href,
    input  logic [7:0]      cam_data,
    output logic            frame_start,
    output logic            pix_valid,
    output cam_pkg::pixel_t pix_data
);
    import cam_pkg::*;

    cap_state_e state;
    logic       vsync_d;
    logic       href_d;
    logic       vs_rise;
    logic       href_rise;
    logic       lo_next;    // Next byte on href is the low byte
    logic       take_hi;
    logic       take_lo;
    logic [7:0] hi_byte;    // Held until its partner arrives

    assign vs_rise   = cam_vsync & ~vsync_d;
    assign href_rise = cam_href & ~href_d;

    // Pulse on entry to ACTIVE and on every later frame
    assign frame_start = vs_rise && (state != WAIT_CFG);

    // A line always opens with a high byte
    assign take_lo = (state == ACTIVE) && cam_href && lo_next && !href_rise;
    assign take_hi = (state == ACTIVE) && cam_href && !take_lo;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state     <= WAIT_CFG;
            vsync_d   <= 1'b0;
            href_d    <= 1'b0;
            lo_next   <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            vsync_d   <= cam_vsync;
            href_d    <= cam_href;
            lo_next   <= take_hi;
            pix_valid <= take_lo;           // One cycle after the low byte
            case (state)
                WAIT_CFG: if (cfg_done) state <= WAIT_VS;
                WAIT_VS:  if (vs_rise)  state <= ACTIVE;
                ACTIVE:   state <= ACTIVE;
                default:  state <= WAIT_CFG;
            endcase
        end
    end

    // Pixel payload
    always_ff @(posedge sys_clk) begin
        if (take_hi) begin
            hi_byte <= cam_data;
        end
        if (take_lo) begin
            pix_data <= {hi_byte, cam_data};
        end
    end

endmodule

//--- logic/frame_buffer.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

module frame_buffer (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  logic            frame_start,
    input  logic            pix_valid,
    input  cam_pkg::pixel_t pix_data,
    input  logic            vt_frame_start,
    input  logic            rd_en,
    output cam_pkg::pixel_t rd_data
);
    import cam_pkg::*;

    localparam int            DEPTH     = `CAM_H_ACT * `CAM_V_ACT;
    localparam int            AW        = $clog2(DEPTH);
    localparam logic [AW-1:0] ADDR_LAST = AW'(DEPTH - 1);

    pixel_t        mem_bank0 [DEPTH];
    pixel_t        mem_bank1 [DEPTH];

    logic [AW-1:0] wr_addr;
    logic          wr_bank;     // Bank being filled
    logic          ready_bank;  // Latest complete bank
    logic          ready_vld;   // Some bank has completed
    logic          wr_fire;
    logic          rd_bank;     // Bank shown this raster frame
    logic          rd_vld;
    logic [AW-1:0] rd_addr;
    logic          sel_bank;
    logic          sel_vld;
    logic [AW-1:0] sel_addr;
    pixel_t        sel_pix;

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    assign wr_fire = pix_valid && !frame_start;     // Restart wins

    always_ff @(posedge sys_clk) begin
        if (wr_fire && !wr_bank) mem_bank0[wr_addr] <= pix_data;
        if (wr_fire &&  wr_bank) mem_bank1[wr_addr] <= pix_data;
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_addr    <= '0;
            wr_bank    <= 1'b0;
            ready_bank <= 1'b0;
            ready_vld  <= 1'b0;
        end else if (frame_start) begin
            wr_addr <= '0;                          // Drop any partial frame
        end else if (pix_valid) begin
            if (wr_addr == ADDR_LAST) begin
                wr_addr    <= '0;
                ready_bank <= wr_bank;              // Publish full frame
                ready_vld  <= 1'b1;
                wr_bank    <= ~wr_bank;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    // First raster cycle already reads from the newly chosen bank
    assign sel_bank = vt_frame_start ? ready_bank : rd_bank;
    assign sel_vld  = vt_frame_start ? ready_vld  : rd_vld;
    assign sel_addr = vt_frame_start ? '0 : rd_addr;
    assign sel_pix  = sel_bank ? mem_bank1[sel_addr] : mem_bank0[sel_addr];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rd_bank <= 1'b0;
            rd_vld  <= 1'b0;
            rd_addr <= '0;
        end else begin
            if (vt_frame_start) begin
                rd_bank <= ready_bank;
                rd_vld  <= ready_vld;
            end
            if (rd_en) begin
                rd_addr <= sel_addr + 1'b1;
            end else if (vt_frame_start) begin
                rd_addr <= '0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rd_en) begin
            rd_data <= sel_vld ? sel_pix : '0;      // Black until a frame lands
        end
    end

endmodule

//--- logic/video_timing.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

module video_timing (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  cam_pkg::pixel_t rd_data,
    output logic            vt_frame_start,
    output logic            rd_en,
    output logic            vid_hsync,
    output logic            vid_vsync,
    output logic            vid_de,
    output cam_pkg::pixel_t vid_data
);

    localparam int            CW      = $clog2(`VID_H_TOTAL);
    localparam int            LW      = $clog2(`VID_V_TOTAL);
    localparam logic [CW-1:0] H_LAST  = CW'(`VID_H_TOTAL - 1);
    localparam logic [CW-1:0] H_ACT   = CW'(`CAM_H_ACT);
    localparam logic [CW-1:0] HS_END  = CW'(`CAM_H_ACT + `VID_HS_LEN);
    localparam logic [LW-1:0] V_LAST  = LW'(`VID_V_TOTAL - 1);
    localparam logic [LW-1:0] V_ACT   = LW'(`CAM_V_ACT);
    localparam logic [LW-1:0] VS_END  = LW'(`CAM_V_ACT + `VID_VS_LEN);

    logic [CW-1:0] h_cnt;   // Column
    logic [LW-1:0] v_cnt;   // Line
    logic          hs_next;
    logic          vs_next;

    // ------------------------------------------------------------
    // Raster counters, free running from reset
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Active area sits at the top left of the raster
    assign rd_en          = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign vt_frame_start = (h_cnt == '0) && (v_cnt == '0);
    assign hs_next        = (h_cnt >= H_ACT) && (h_cnt < HS_END);
    assign vs_next        = (v_cnt >= V_ACT) && (v_cnt < VS_END);    // Whole lines

    // One stage, aligned with the buffer read register
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            vid_de    <= 1'b0;
            vid_hsync <= 1'b0;
            vid_vsync <= 1'b0;
        end else begin
            vid_de    <= rd_en;
            vid_hsync <= hs_next;
            vid_vsync <= vs_next;
        end
    end

    assign vid_data = vid_de ? rd_data : '0;    // Blank outside the active area

endmodule

//--- logic/cam_video_top.sv
`timescale 1ns/1ps

module cam_video_top (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  logic            cam_vsync,
    input  logic            cam_href,
    input  logic [7:0]      cam_data,
    output logic            cam_scl,
    output logic            cam_sda,
    output logic            cfg_done,
    output logic            vid_hsync,
    output logic            vid_vsync,
    output logic            vid_de,
    output cam_pkg::pixel_t vid_data
);
    import cam_pkg::*;

    logic       cfg_req;        // Sequencer to SCCB writer
    logic       cfg_ack;
    logic [7:0] cfg_addr;
    logic [7:0] cfg_data;
    logic       frame_start;    // Capture to frame buffer
    logic       pix_valid;
    pixel_t     pix_data;
    logic       vt_frame_start; // Raster to frame buffer
    logic       rd_en;
    pixel_t     rd_data;

    cam_init_seq u_cam_init_seq (
        .sys_clk (sys_clk ), .rst_n (rst_n ), .cfg_ack (cfg_ack ), .cfg_req (cfg_req ),
        .cfg_addr(cfg_addr), .cfg_data(cfg_data), .cfg_done(cfg_done)
    );

    sccb_writer u_sccb_writer (
        .sys_clk (sys_clk ), .rst_n (rst_n ), .cfg_req (cfg_req ), .cfg_addr(cfg_addr),
        .cfg_data(cfg_data), .cfg_ack (cfg_ack ), .cam_scl (cam_scl ), .cam_sda (cam_sda )
    );

    cam_capture u_cam_capture (
        .sys_clk    (sys_clk    ), .rst_n   (rst_n   ), .cfg_done (cfg_done ),
        .cam_vsync  (cam_vsync  ), .cam_href(cam_href), .cam_data (cam_data ),
        .frame_start(frame_start), .pix_valid(pix_valid), .pix_data(pix_data)
    );

    frame_buffer u_frame_buffer (
        .sys_clk       (sys_clk       ), .rst_n    (rst_n    ), .frame_start(frame_start),
        .pix_valid     (pix_valid     ), .pix_data (pix_data ), .rd_en      (rd_en      ),
        .vt_frame_start(vt_frame_start), .rd_data  (rd_data  )
    );

    video_timing u_video_timing (
        .sys_clk  (sys_clk  ), .rst_n    (rst_n    ), .rd_data(rd_data), .rd_en(rd_en),
        .vt_frame_start(vt_frame_start), .vid_hsync(vid_hsync), .vid_vsync(vid_vsync),
        .vid_de   (vid_de   ), .vid_data (vid_data )
    );

endmodule

//--- sim/cam_video_checker.sv
`timescale 1ns/1ps

module cam_video_checker (
    input logic sys_clk,
    input logic rst_n,
    input logic cfg_req,
    input logic cfg_ack,
    input logic cam_scl,
    input logic cam_sda,
    input logic vid_de,
    input logic vid_hsync,
    input logic vid_vsync
);

    int fail_cnt = 0;   // Polled by the testbench

    // ------------------------------------------------------------
    // Four-phase handshake
    // ------------------------------------------------------------
    req_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        cfg_req && !cfg_ack |=> cfg_req)
        else begin
            fail_cnt++;
            $error("cfg_req fell before cfg_ack rose");
        end

    ack_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        cfg_req && cfg_ack |=> cfg_ack)
        else begin
            fail_cnt++;
            $error("cfg_ack fell before cfg_req fell");
        end

    // No active video inside sync
    de_sync: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(vid_de && (vid_hsync || vid_vsync)))
        else begin
            fail_cnt++;
            $error("vid_de high together with a sync");
        end

    // SDA moves with SCL high only as start or stop
    // Start comes two cycles after an idle request line, stop with the ack
    sda_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $changed(cam_sda) && cam_scl && $past(cam_scl) |->
            ($fell(cam_sda) && !$past(cfg_req, 2)) || ($rose(cam_sda) && $rose(cfg_ack)))
        else begin
            fail_cnt++;
            $error("cam_sda changed while cam_scl high");
        end

endmodule

bind cam_video_top cam_video_checker u_cam_video_checker (
    .sys_clk  (sys_clk  ),
    .rst_n    (rst_n    ),
    .cfg_req  (cfg_req  ),
    .cfg_ack  (cfg_ack  ),
    .cam_scl  (cam_scl  ),
    .cam_sda  (cam_sda  ),
    .vid_de   (vid_de   ),
    .vid_hsync(vid_hsync),
    .vid_vsync(vid_vsync)
);

//--- sim/tb_cam_video.sv
`timescale 1ns/1ps
`include "cam_consts.svh"

module tb_cam_video;
    import cam_pkg::*;

    localparam int FRAME_CYC = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int NUM_ROWS  = 6;
    localparam int SCCB_CYC  = `CFG_NUM * (2 * `SCCB_DIV * 30 + 16);    // Generous per write
    localparam int LIMIT     = (NUM_ROWS + 4) * FRAME_CYC + SCCB_CYC;

    typedef struct packed {
        logic [7:0] seed;       // Pattern of the driven frame
        logic       cut;        // Frame ends after half its lines
        logic [7:0] exp_seed;   // Pattern shown two raster frames later
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'h11, 1'b0, 8'h11},
        '{8'h23, 1'b0, 8'h23},
        '{8'h37, 1'b1, 8'h23},  // Short frame, old picture stays
        '{8'h4c, 1'b0, 8'h4c},
        '{8'h58, 1'b1, 8'h4c},
        '{8'h6e, 1'b0, 8'h6e}
    };

    // Expected sensor writes, address then value
    localparam logic [15:0] REG_TABLE [`CFG_NUM] = '{
        16'h1246, 16'h0c10, 16'h1722, 16'h18a4, 16'h1907, 16'h1af0
    };

    logic        sys_clk;
    logic        rst_n;
    logic        cam_vsync;
    logic        cam_href;
    logic [7:0]  cam_data;
    logic        cam_scl;
    logic        cam_sda;
    logic        cfg_done;
    logic        vid_hsync;
    logic        vid_vsync;
    logic        vid_de;
    pixel_t      vid_data;

    int          cyc = 0;
    int          err_cnt = 0;
    logic [7:0]  exp_q [$];     // One expected seed per raster frame
    logic [7:0]  cur_seed = 8'h00;
    logic        scl_d = 1'b1;
    logic        sda_d = 1'b1;
    logic [27:0] sccb_bits = '0;
    int          sccb_cnt = 0;
    int          wr_cnt = 0;
    int          pix_cnt = 0;
    int          de_run = 0;
    int          line_cnt = 0;
    int          hs_last = -1;
    int          vs_last = -1;
    logic        de_d = 1'b0;
    logic        hs_d = 1'b0;
    logic        vs_d = 1'b0;

    cam_video_top u_cam_video_top (
        .sys_clk  (sys_clk  ), .rst_n    (rst_n    ), .cam_vsync(cam_vsync),
        .cam_href (cam_href ), .cam_data (cam_data ), .cam_scl  (cam_scl  ),
        .cam_sda  (cam_sda  ), .cfg_done (cfg_done ), .vid_hsync(vid_hsync),
        .vid_vsync(vid_vsync), .vid_de   (vid_de   ), .vid_data (vid_data )
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // Seed 0 stands for no captured frame, black
    function automatic pixel_t pattern_pixel(input logic [7:0] seed, input int x, input int y);
        if (seed == 8'h00) return '0;
        return {seed ^ 8'(x * 13), 8'(y * `CAM_H_ACT + x) ^ ~seed};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            err_cnt++;
            $display("Fail at %0t ns: %s, got %0h expected %0h", $time, msg, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge sys_clk);
            cam_href <= 1'b0;
            cam_data <= 8'($urandom);  // Fill byte
        end
    endtask

    task automatic drive_frame(input logic [7:0] seed, input logic cut);
        int     lines;
        pixel_t pix;
        lines = cut ? `CAM_V_ACT / 2 : `CAM_V_ACT;
        @(posedge sys_clk);
        cam_vsync <= 1'b1;          // Frame start
        cam_href  <= 1'b0;
        @(posedge sys_clk);
        cam_vsync <= 1'b0;
        for (int y = 0; y < lines; y++) begin
            for (int x = 0; x < `CAM_H_ACT; x++) begin
                pix = pattern_pixel(seed, x, y);
                @(posedge sys_clk);
                cam_href <= 1'b1;
                cam_data <= pix[15:8];  // High byte first
                @(posedge sys_clk);
                cam_data <= pix[7:0];
            end
            idle_cycles(2);         // Line gap
        end
    endtask

    // Next vid_vsync rise, line CAM_V_ACT of the raster
    task automatic wait_vsync_rise();
        @(negedge sys_clk);
        while (vid_vsync) @(negedge sys_clk);
        while (!vid_vsync) @(negedge sys_clk);
    endtask

    // ------------------------------------------------------------
    // Run limit and bound assertion failures
    // ------------------------------------------------------------
    always @(posedge sys_clk) begin
        cyc++;
        if (cyc >= LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout");
        end else if (u_cam_video_top.u_cam_video_checker.fail_cnt != 0) begin
            $display("An assertion in the bound checker failed at %0t ns", $time);
            $display("Simulation finished: FAIL");
            $fatal(1, "Assertion failure");
        end
    end

    // SCCB decoder, sampled away from the clock edge
    always @(negedge sys_clk) begin
        if (rst_n) begin
            if (cam_scl && scl_d && sda_d && !cam_sda) begin
                sccb_cnt = 0;                       // Start
            end else if (cam_scl && scl_d && !sda_d && cam_sda) begin
                // Stop, bit 28 is the low SDA ahead of the stop edge
                check(wr_cnt < `CFG_NUM, 1'b1, "SCCB write beyond the table");
                check(sccb_cnt, 28, "SCCB bit count");
                check(sccb_bits[27:20], `SCCB_ID, "SCCB ID byte");
                check(sccb_bits[18:11], REG_TABLE[wr_cnt][15:8], "SCCB register address");
                check(sccb_bits[9:2], REG_TABLE[wr_cnt][7:0], "SCCB register data");
                check({sccb_bits[19], sccb_bits[10], sccb_bits[1]}, 3'b111,
                      "SCCB don't-care bits");
                check(cfg_done, 1'b0, "cfg_done during configuration");
                wr_cnt++;
            end else if (cam_scl && !scl_d) begin
                sccb_bits = {sccb_bits[26:0], cam_sda};
                sccb_cnt++;
            end
        end
        scl_d = cam_scl;
        sda_d = cam_sda;
    end

    // ------------------------------------------------------------
    // Video scoreboard and raster timing
    // ------------------------------------------------------------
    always @(negedge sys_clk) begin
        if (rst_n) begin
            if (vid_de) begin
                if (pix_cnt == 0 && exp_q.size() > 0) cur_seed = exp_q.pop_front();
                check(vid_data,
                      pattern_pixel(cur_seed, pix_cnt % `CAM_H_ACT, pix_cnt / `CAM_H_ACT),
                      $sformatf("pixel x=%0d y=%0d", pix_cnt % `CAM_H_ACT,
                                pix_cnt / `CAM_H_ACT));
                pix_cnt++;
                de_run++;
            end else if (de_d) begin
                check(de_run, `CAM_H_ACT, "vid_de cycles per line");
                de_run = 0;
                line_cnt++;
            end
            if (vid_hsync && !hs_d) begin
                if (hs_last >= 0) check(cyc - hs_last, `VID_H_TOTAL, "hsync period");
                hs_last = cyc;
            end
            if (vid_vsync && !vs_d) begin
                check(line_cnt, `CAM_V_ACT, "active lines per frame");
                if (vs_last >= 0) check(cyc - vs_last, FRAME_CYC, "vsync period");
                vs_last  = cyc;
                line_cnt = 0;
                pix_cnt  = 0;
            end
        end
        de_d = vid_de;
        hs_d = vid_hsync;
        vs_d = vid_vsync;
    end

    initial begin
        void'($urandom(92498));
        rst_n     = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = 8'h00;
        repeat (3) @(posedge sys_clk);
        rst_n <= 1'b1;

        drive_frame(8'h5a, 1'b0);               // Sensor not configured yet
        @(negedge sys_clk);
        while (!cfg_done) @(negedge sys_clk);
        check(wr_cnt, `CFG_NUM, "SCCB writes before cfg_done");

        // Row i starts at a vsync rise and shows two raster frames later
        wait_vsync_rise();
        exp_q.push_back(8'h00);                 // Frame shown while row 0 is captured
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i > 0) wait_vsync_rise();
            exp_q.push_back(ROWS[i].exp_seed);
            drive_frame(ROWS[i].seed, ROWS[i].cut);
        end
        repeat (2) wait_vsync_rise();            // Last row on screen and checked

        check(exp_q.size(), 0, "raster frames left unchecked");
        if (err_cnt == 0 && u_cam_video_top.u_cam_video_checker.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/cam_pkg.sv
logic/sccb_writer.sv
logic/cam_init_seq.sv
logic/cam_capture.sv
logic/frame_buffer.sv
logic/video_timing.sv
logic/cam_video_top.sv
sim/cam_video_checker.sv
sim/tb_cam_video.sv

//--- Bender.yml
package:
  name: cam_video

sources:
  - include_dirs:
      - logic
    files:
      - logic/cam_pkg.sv
      - logic/sccb_writer.sv
      - logic/cam_init_seq.sv
      - logic/cam_capture.sv
      - logic/frame_buffer.sv
      - logic/video_timing.sv
      - logic/cam_video_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/cam_video_checker.sv
      - sim/tb_cam_video.sv
